// File: files.f
+incdir+rtl
rtl/stat_pkg.sv
rtl/stat_pipe.sv
rtl/stat_timer.sv
rtl/stat_regs.sv
rtl/stat_ctrl_fsm.sv
rtl/stat_bridge_top.sv
verif/stat_bridge_assert.sv
verif/tb_stat_bridge.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_stat_bridge -f files.f -Mdir obj_dir -o sim_stat_bridge

if ! out=$(./obj_dir/sim_stat_bridge 2>&1)
then
  printf '%s\n' "$out"
  exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Verification passed"
then
  exit 0
fi
exit 1

// File: verif/tb_stat_bridge.sv
`default_nettype none

`include "stat_cfg.svh"

module tb_stat_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CHAN = `STAT_NUM_CHAN;
  localparam int NUM_REQ  = 150;
  localparam int LATENCY  = `STAT_LATENCY;
  localparam int MAX_GAP  = 3;
  localparam int IDX_W    = $clog2(`STAT_NUM_REGS);
  localparam int TIMEOUT  = NUM_REQ * (LATENCY + 4) + 100;

  logic                clk = 1'b0;
  logic                sync_rst_n;
  stat_pkg::stat_req_t stat_req [NUM_CHAN];
  stat_pkg::stat_rsp_t stat_rsp [NUM_CHAN];

  // --------------------
  // Reference model
  // --------------------
  logic [`STAT_DATA_W-1:0] model_regs [NUM_CHAN][`STAT_NUM_REGS];
  stat_pkg::stat_rsp_t     exp_q      [NUM_CHAN][$];
  int                      due_q      [NUM_CHAN][$];

  // Stimulus state per channel
  int                      issued       [NUM_CHAN];
  int                      gap          [NUM_CHAN];
  logic                    busy         [NUM_CHAN];
  logic [`STAT_ADDR_W-1:0] last_wr_addr [NUM_CHAN];

  int cyc;
  int timeout_cnt = 0;

  stat_bridge_top u_dut (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .stat_req   (stat_req),
    .stat_rsp   (stat_rsp)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    timeout_cnt++;
    if (timeout_cnt >= TIMEOUT)
    begin
      $display("Run hung: test did not end within %0d cycles", TIMEOUT);
      $display("Verification failed");
      $fatal(1, "Timeout");
    end
  end

  // Applies one access to the model and returns the response it must produce
  function automatic stat_pkg::stat_rsp_t model_access(input int ch,
                                                       input stat_pkg::stat_req_t req);
    stat_pkg::stat_rsp_t rsp;
    logic                hit;
    hit     = (req.addr < `STAT_NUM_REGS);
    rsp     = '0;
    rsp.ack = 1'b1;
    if (req.wr && hit)
    begin
      model_regs[ch][req.addr[IDX_W-1:0]] = req.wdata;
    end
    if (req.rd && hit)
    begin
      rsp.rdata = model_regs[ch][req.addr[IDX_W-1:0]];
    end
    rsp.intr = model_regs[ch][0][`STAT_INT_W-1:0];
    return rsp;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_rsp(input int ch, input stat_pkg::stat_rsp_t got,
                           input stat_pkg::stat_rsp_t exp);
    if (got !== exp)
    begin
      $display("ERR t=%0t stat_rsp[%0d] got %h exp %h", $time, ch, got, exp);
      $display("  ack %b/%b intr %h/%h rdata %h/%h", got.ack, exp.ack,
               got.intr, exp.intr, got.rdata, exp.rdata);
      $display("Verification failed");
      $fatal(1, "Response mismatch");
    end
  endtask

  task automatic check_idle(input int ch, input stat_pkg::stat_rsp_t got);
    stat_pkg::stat_rsp_t zero;
    zero = '0;
    if (got !== zero)
    begin
      $display("ERR t=%0t stat_rsp[%0d] got %h exp %h", $time, ch, got, zero);
      $display("Verification failed");
      $fatal(1, "Response outside ack cycle");
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic issue_req(input int ch);
    stat_pkg::stat_req_t req;
    req       = '0;
    req.wdata = $urandom();
    // First access of each channel reads a register straight after reset
    if (issued[ch] == 0 || $urandom_range(0, 1) == 0)
    begin
      req.rd = 1'b1;
    end
    else
    begin
      req.wr = 1'b1;
    end
    if (issued[ch] != 0 && req.rd && $urandom_range(0, 3) == 0)
    begin
      req.addr = last_wr_addr[ch];
    end
    else if ($urandom_range(0, 7) == 0)
    begin
      req.addr = `STAT_ADDR_W'($urandom_range(16, 255));
    end
    else if ($urandom_range(0, 7) == 0)
    begin
      req.addr = '0;
    end
    else
    begin
      req.addr = `STAT_ADDR_W'($urandom_range(0, 15));
    end
    if (req.wr)
    begin
      last_wr_addr[ch] = req.addr;
    end
    stat_req[ch] = req;
    exp_q[ch].push_back(model_access(ch, req));
    due_q[ch].push_back(cyc + LATENCY);
    issued[ch]++;
    busy[ch] = 1'b1;
  endtask

  task automatic drive_step();
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      // Idle cycles carry random don't-care fields
      stat_req[ch]       = '0;
      stat_req[ch].addr  = `STAT_ADDR_W'($urandom());
      stat_req[ch].wdata = $urandom();
      if (!busy[ch] && issued[ch] < NUM_REQ)
      begin
        if (gap[ch] == 0)
        begin
          issue_req(ch);
        end
        else
        begin
          gap[ch]--;
        end
      end
    end
  endtask

  task automatic check_step();
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      if (due_q[ch].size() != 0 && due_q[ch][0] == cyc)
      begin
        check_rsp(ch, stat_rsp[ch], exp_q[ch][0]);
        void'(exp_q[ch].pop_front());
        void'(due_q[ch].pop_front());
        busy[ch] = 1'b0;
        gap[ch]  = $urandom_range(0, MAX_GAP);
      end
      else
      begin
        check_idle(ch, stat_rsp[ch]);
      end
    end
  endtask

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      if (issued[ch] < NUM_REQ || due_q[ch].size() != 0)
      begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  initial
  begin
    void'($urandom(32'h70e3_1393));
    sync_rst_n = 1'b0;
    cyc        = 0;
    for (int ch = 0; ch < NUM_CHAN; ch++)
    begin
      stat_req[ch]     = '0;
      issued[ch]       = 0;
      busy[ch]         = 1'b0;
      last_wr_addr[ch] = '0;
      gap[ch]          = $urandom_range(0, MAX_GAP);
      for (int r = 0; r < `STAT_NUM_REGS; r++)
      begin
        model_regs[ch][r] = '0;
      end
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    sync_rst_n = 1'b1;

    while (!all_done())
    begin
      @(negedge clk);
      cyc++;
      drive_step();
      check_step();
    end

    // Quiet tail catches a late or repeated ack
    repeat (LATENCY)
    begin
      @(negedge clk);
      cyc++;
      drive_step();
      check_step();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/stat_bridge_assert.sv
`default_nettype none

`include "stat_cfg.svh"

// Status bus protocol checks on every channel of the bridge
module stat_bridge_assert (
  input logic                clk,
  input logic                sync_rst_n,
  input stat_pkg::stat_req_t stat_req [`STAT_NUM_CHAN],
  input stat_pkg::stat_rsp_t stat_rsp [`STAT_NUM_CHAN]
);

  timeunit 1ns;
  timeprecision 1ps;

  for (genvar ch = 0; ch < `STAT_NUM_CHAN; ch++)
  begin : g_chan
    logic                     req_valid;
    logic [`STAT_LATENCY-1:0] req_hist;
    logic                     pending;

    assign req_valid = stat_req[ch].wr || stat_req[ch].rd;

    // Request history lines each ack up with its request
    always_ff @(posedge clk or negedge sync_rst_n)
    begin
      if (!sync_rst_n)
      begin
        req_hist <= '0;
        pending  <= 1'b0;
      end
      else
      begin
        req_hist <= {req_hist[`STAT_LATENCY-2:0], req_valid};
        if (req_valid)
        begin
          pending <= 1'b1;
        end
        else if (stat_rsp[ch].ack)
        begin
          pending <= 1'b0;
        end
      end
    end

    // --------------------
    // Protocol properties
    // --------------------
    a_wr_rd_excl : assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(stat_req[ch].wr && stat_req[ch].rd))
      else $error("Channel %0d: wr and rd high together", ch);

    a_ack_latency : assert property (@(posedge clk) disable iff (!sync_rst_n)
      req_hist[`STAT_LATENCY-1] == stat_rsp[ch].ack)
      else $error("Channel %0d: ack not at the fixed request latency", ch);

    a_one_outstanding : assert property (@(posedge clk) disable iff (!sync_rst_n)
      req_valid |-> !pending)
      else $error("Channel %0d: new request before previous ack", ch);

    a_ack_single : assert property (@(posedge clk) disable iff (!sync_rst_n)
      stat_rsp[ch].ack |=> !stat_rsp[ch].ack)
      else $error("Channel %0d: ack high for two cycles", ch);
  end

endmodule

bind stat_bridge_top stat_bridge_assert u_assert (
  .clk        (clk),
  .sync_rst_n (sync_rst_n),
  .stat_req   (stat_req),
  .stat_rsp   (stat_rsp)
);

`default_nettype wire

// File: rtl/stat_bridge_top.sv
`default_nettype none

`include "stat_cfg.svh"

// Status bus bridge, one independent retimed channel per status port
module stat_bridge_top (
  input  logic                clk,
  input  logic                sync_rst_n,
  input  stat_pkg::stat_req_t stat_req [`STAT_NUM_CHAN],
  output stat_pkg::stat_rsp_t stat_rsp [`STAT_NUM_CHAN]
);

  for (genvar ch = 0; ch < `STAT_NUM_CHAN; ch++)
  begin : g_chan
    stat_pkg::stat_req_t req_q;
    stat_pkg::stat_rsp_t rsp_d;

    // --------------------
    // Request retiming
    // --------------------
    stat_pipe #(
      .T_PAYLOAD (stat_pkg::stat_req_t),
      .STAGES    (`STAT_PIPE_STAGES)
    ) u_req_pipe (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .din        (stat_req[ch]),
      .dout       (req_q)
    );

    // Local target with fixed access delay
    stat_ctrl_fsm u_ctrl (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .req        (req_q),
      .rsp        (rsp_d)
    );

    // --------------------
    // Response retiming
    // --------------------
    // Mirrors the request side so both directions see the same delay
    stat_pipe #(
      .T_PAYLOAD (stat_pkg::stat_rsp_t),
      .STAGES    (`STAT_PIPE_STAGES)
    ) u_rsp_pipe (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .din        (rsp_d),
      .dout       (stat_rsp[ch])
    );
  end

endmodule

`default_nettype wire

// File: rtl/stat_ctrl_fsm.sv
`default_nettype none

`include "stat_cfg.svh"

// Local status target control, stands in for the memory controller
module stat_ctrl_fsm (
  input  logic                clk,
  input  logic                sync_rst_n,
  input  stat_pkg::stat_req_t req,
  output stat_pkg::stat_rsp_t rsp
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } state_t;

  state_t                  state_q;
  state_t                  state_d;
  stat_pkg::stat_req_t     req_q;
  stat_pkg::stat_rsp_t     rsp_d;
  logic                    req_valid;
  logic                    start;
  logic                    done;
  logic                    access;
  logic [`STAT_DATA_W-1:0] rdata;
  logic [`STAT_INT_W-1:0]  intr;

  assign req_valid = req.wr || req.rd;
  // Requests outside IDLE break the bus protocol and are dropped
  assign start     = (state_q == IDLE) && req_valid;
  assign access    = (state_q == RESP);

  // --------------------
  // State register
  // --------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE: if (req_valid) state_d = WAIT;
      WAIT: if (done) state_d = RESP;
      RESP: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Held request, only read while WAIT or RESP
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      req_q <= req;
    end
  end

  // --------------------
  // Response
  // --------------------
  always_comb
  begin
    rsp_d = '0;
    if (access)
    begin
      rsp_d.ack   = 1'b1;
      rsp_d.intr  = intr;
      rsp_d.rdata = req_q.rd ? rdata : '0;
    end
  end

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      rsp <= '0;
    end
    else
    begin
      rsp <= rsp_d;
    end
  end

  stat_timer u_timer (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .start      (start),
    .done       (done)
  );

  stat_regs u_regs (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .access     (access),
    .req        (req_q),
    .rdata      (rdata),
    .intr       (intr)
  );

endmodule

`default_nettype wire

// File: rtl/stat_regs.sv
`default_nettype none

`include "stat_cfg.svh"

// Per channel status register file behind the local target
module stat_regs (
  input  logic                    clk,
  input  logic                    sync_rst_n,
  input  logic                    access,
  input  stat_pkg::stat_req_t     req,
  output logic [`STAT_DATA_W-1:0] rdata,
  output logic [`STAT_INT_W-1:0]  intr
);

  localparam int IDX_W = $clog2(`STAT_NUM_REGS);

  logic [`STAT_DATA_W-1:0] regs_q [`STAT_NUM_REGS];
  logic [IDX_W-1:0]        idx;
  logic                    hit;
  logic                    wr_en;

  // --------------------
  // Address decode
  // --------------------
  // Addresses past the implemented range are silently dropped
  assign hit   = (req.addr < `STAT_NUM_REGS);
  assign idx   = req.addr[IDX_W-1:0];
  assign wr_en = access && req.wr && hit;

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < `STAT_NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs_q[idx] <= req.wdata;
    end
  end

  // --------------------
  // Read side
  // --------------------
  assign rdata = hit ? regs_q[idx] : '0;

  // Register 0 low byte is the interrupt status
  // A write to it in this cycle is forwarded so the ack carries the new value
  always_comb
  begin
    if (wr_en && (idx == '0))
    begin
      intr = req.wdata[`STAT_INT_W-1:0];
    end
    else
    begin
      intr = regs_q[0][`STAT_INT_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: rtl/stat_timer.sv
`default_nettype none

`include "stat_cfg.svh"

// Access delay counter for the local status target
module stat_timer (
  input  logic clk,
  input  logic sync_rst_n,
  input  logic start,
  output logic done
);

  localparam int CNT_W = $clog2(`STAT_ACK_DELAY + 1);

  logic [CNT_W-1:0] cnt_q;

  // The start cycle is the first cycle of the delay, so the count
  // holds the cycles still to go after it
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      cnt_q <= '0;
    end
    else if (start)
    begin
      cnt_q <= CNT_W'(`STAT_ACK_DELAY - 1);
    end
    else if (cnt_q != '0)
    begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // One cycle pulse in the last cycle of the delay
  assign done = (cnt_q == CNT_W'(1));

endmodule

`default_nettype wire

// File: rtl/stat_pipe.sv
`default_nettype none

// Retiming chain for the status bus, one instance per direction
module stat_pipe #(
  parameter type T_PAYLOAD = logic,
  parameter int  STAGES    = 1
) (
  input  logic     clk,
  input  logic     sync_rst_n,
  input  T_PAYLOAD din,
  output T_PAYLOAD dout
);

  T_PAYLOAD stage_q [STAGES];

  // Every stage clears so no stray wr, rd or ack leaves after reset
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      for (int i = 0; i < STAGES; i++)
      begin
        stage_q[i] <= '0;
      end
    end
    else
    begin
      stage_q[0] <= din;
      for (int i = 1; i < STAGES; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout = stage_q[STAGES-1];

endmodule

`default_nettype wire

// File: rtl/stat_pkg.sv
`default_nettype none

`include "stat_cfg.svh"

package stat_pkg;

  // --------------------
  // Status bus request
  // --------------------
  // At most one of wr and rd is high, for a single cycle
  typedef struct packed {
    logic                    wr;
    logic                    rd;
    logic [`STAT_ADDR_W-1:0] addr;
    logic [`STAT_DATA_W-1:0] wdata;
  } stat_req_t;

  // --------------------
  // Status bus response
  // --------------------
  // All zeros except in the ack cycle
  typedef struct packed {
    logic                    ack;
    logic [`STAT_INT_W-1:0]  intr;
    logic [`STAT_DATA_W-1:0] rdata;
  } stat_rsp_t;

endpackage

`default_nettype wire

// File: rtl/stat_cfg.svh
`ifndef STAT_CFG_SVH
`define STAT_CFG_SVH

// --------------------
// Status bus widths
// --------------------
`define STAT_ADDR_W       8
`define STAT_DATA_W       32
`define STAT_INT_W        8

// --------------------
// Bridge structure
// --------------------
// Register stages in each direction
`define STAT_PIPE_STAGES  4
`define STAT_NUM_CHAN     3
// Implemented registers per channel target
`define STAT_NUM_REGS     16
// Target access delay in cycles
`define STAT_ACK_DELAY    3

// Request at top input to ack at top output
`define STAT_LATENCY      (2 * `STAT_PIPE_STAGES + `STAT_ACK_DELAY + 1)

`endif
